// ==== project.f ====
logic/scan_pkg.sv
logic/page_scan_fsm.sv
logic/column_fifo_bank.sv
logic/page_scan_top.sv
testbench/page_scan_props.sv
testbench/page_scan_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the page scanner testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f project.f \
  --top-module page_scan_tb \
  --Mdir obj_dir \
  -o page_scan_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/page_scan_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// ==== testbench/page_scan_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module page_scan_tb;

  import scan_pkg::*;

  localparam int PAGE_BEATS  = 8;                  // short pages
  localparam int FIFO_DEPTH  = 4;                  // small bank so rows get lost
  localparam int RUN_PAGES   = 8;                  // page ends before drain
  localparam int PAGE_CYCLES = 16 + 2 * PAGE_BEATS;   // address search plus gaps
  localparam int MAX_CYCLES  = 2 * (4 + RUN_PAGES * PAGE_CYCLES + 2 * FIFO_DEPTH);

  logic        clk;
  logic        rst;
  page_addr_t  target_page_addr;
  logic [31:0] record_num;
  page_addr_t  read_page_addr;
  logic        data_valid;
  beat_u       data_in;
  logic        rd_en;
  row_t        row_out;
  logic        row_empty;
  logic        page_hit;
  logic        table_scan_done;

  logic [31:0] seed = 32'h9b50_009c;               // lcg state
  int          cycles = 0;                         // watchdog count
  scan_state_t m_state = wait_page;                // model of the scanner
  int          m_beat = 0;                         // beats of current page
  logic [31:0] m_rows = '0;                        // rows toward record_num
  page_addr_t  m_link = '0;
  logic        m_link_vld = 1'b0;
  logic        m_hit = 1'b0;
  logic        m_done = 1'b0;
  int          page_ends = 0;
  row_t        exp_q[$];                           // rows the bank should hold

  page_scan_top #(
    .PAGE_BEATS (PAGE_BEATS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut_i (
    .clk              (clk),
    .rst              (rst),
    .target_page_addr (target_page_addr),
    .record_num       (record_num),
    .read_page_addr   (read_page_addr),
    .data_valid       (data_valid),
    .data_in          (data_in),
    .rd_en            (rd_en),
    .row_out          (row_out),
    .row_empty        (row_empty),
    .page_hit         (page_hit),
    .table_scan_done  (table_scan_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;                         // 8 ns period
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    if (got !== exp)
    begin
      $display("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic compare_outputs();
    check_value("row_empty", 256'(row_empty), 256'(exp_q.size() == 0));
    check_value("page_hit", 256'(page_hit), 256'(m_hit));
    check_value("table_scan_done", 256'(table_scan_done), 256'(m_done));
    if (exp_q.size() != 0)
      check_value("row_out", row_out, exp_q[0]);   // show-ahead head row
  endtask

  task automatic pick_inputs();
    logic [31:0] r;
    r = next_rand();
    case (r[31:29])
      3'd0:    read_page_addr = target_page_addr;
      3'd1:    read_page_addr = m_link_vld ? m_link : 32'd0;
      3'd2:    read_page_addr = 32'd0;             // never a hit before a header
      default: read_page_addr = next_rand();
    endcase
    r = next_rand();
    data_valid = (r[31:30] != 2'b00);              // gaps on a quarter of cycles
    for (int c = 0; c < COL_COUNT; c++)
      data_in.row.col[c] = next_rand();
    r = next_rand();
    rd_en = r[31];
  endtask

  // one clock edge of the scanner and bank rules
  task automatic model_step();
    logic addr_hit;
    logic was_full;
    logic take_row;
    addr_hit = (read_page_addr == target_page_addr) ||
               (m_link_vld && (read_page_addr == m_link));
    was_full = (exp_q.size() == FIFO_DEPTH);
    take_row = (m_state == load_rows) && data_valid && !was_full &&
               (m_rows < record_num);
    if (rd_en && (exp_q.size() != 0))
      void'(exp_q.pop_front());
    if (take_row)
      exp_q.push_back(data_in.row);
    case (m_state)
      wait_page:
        if (addr_hit)
          m_state = wait_header;
      wait_header:
        if (data_valid)
        begin
          m_link     = data_in.hdr.next_page;      // header beat, beat 1
          m_link_vld = 1'b1;
          m_beat     = 1;
          m_state    = load_rows;
        end
      default:
        if (data_valid)
        begin
          m_beat = m_beat + 1;
          if (take_row)
          begin
            m_rows = m_rows + 32'd1;
            if (m_rows == record_num)
            begin
              m_done  = 1'b1;
              m_rows  = '0;
              m_state = skip_tail;
            end
          end
          if (m_beat == PAGE_BEATS)
          begin
            m_state   = wait_page;                 // page end wins
            m_beat    = 0;
            page_ends = page_ends + 1;
          end
        end
    endcase
    m_hit = (m_state != wait_page);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rst              = 1'b0;
    target_page_addr = 32'h0000_a5c0;
    record_num       = 32'd9;                      // spans two pages at least
    read_page_addr   = '0;
    data_valid       = 1'b0;
    data_in          = '0;
    rd_en            = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    while (page_ends < RUN_PAGES)
    begin
      compare_outputs();
      pick_inputs();
      model_step();
      @(negedge clk);
    end
    while (exp_q.size() != 0)                      // drain the bank
    begin
      compare_outputs();
      read_page_addr = target_page_addr + 32'd1;
      data_valid     = 1'b0;
      rd_en          = 1'b1;
      model_step();
      @(negedge clk);
    end
    compare_outputs();
    if (!m_done)
    begin
      $display("table_scan_done was never reached during the run");
      $display("Regression failed");
      $fatal(1);
    end
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule : page_scan_tb

`default_nettype wire

// ==== testbench/page_scan_props.sv ====
`default_nettype none
`timescale 1ns/10ps

module page_scan_props (
  input logic clk,
  input logic rst,                                 // async, active low
  input logic wr_en,                               // fsm push strobe
  input logic full,                                // bank full flag
  input logic row_empty,
  input logic table_scan_done
);

  // fsm must check full before a push
  no_push_when_full: assert property (@(posedge clk) disable iff (!rst)
    !(wr_en && full))
    else $error("wr_en high while the bank is full");

  done_sticky: assert property (@(posedge clk) disable iff (!rst)
    table_scan_done |=> table_scan_done)           // level, only reset clears
    else $error("table_scan_done fell without reset");

  flags_exclusive: assert property (@(posedge clk) disable iff (!rst)
    !(row_empty && full))                          // depth is never zero
    else $error("row_empty and full high together");

endmodule : page_scan_props

bind page_scan_top page_scan_props props_i (
  .clk             (clk),
  .rst             (rst),
  .wr_en           (wr_en),
  .full            (full),
  .row_empty       (row_empty),
  .table_scan_done (table_scan_done)
);

`default_nettype wire

// ==== logic/page_scan_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module page_scan_top #(
  parameter int PAGE_BEATS = 128,                  // beats per page, header included
  parameter int FIFO_DEPTH = 16                    // rows in the column bank
) (
  input  logic                 clk,
  input  logic                 rst,                // async, active low
  input  scan_pkg::page_addr_t target_page_addr,   // held during a scan
  input  logic [31:0]          record_num,         // held during a scan
  input  scan_pkg::page_addr_t read_page_addr,
  input  logic                 data_valid,
  input  scan_pkg::beat_u      data_in,
  input  logic                 rd_en,              // pop one row
  output scan_pkg::row_t       row_out,            // head row
  output logic                 row_empty,
  output logic                 page_hit,
  output logic                 table_scan_done
);

  import scan_pkg::*;

  logic wr_en;                                     // fsm push strobe
  row_t wr_row;                                    // row pushed with wr_en
  logic full;                                      // bank back to fsm

  //////////////////////////////////////////////////////////////////////
  // scanner and row storage
  //////////////////////////////////////////////////////////////////////

  page_scan_fsm #(
    .PAGE_BEATS (PAGE_BEATS)
  ) fsm_i (
    .clk              (clk),
    .rst              (rst),
    .target_page_addr (target_page_addr),
    .record_num       (record_num),
    .read_page_addr   (read_page_addr),
    .data_valid       (data_valid),
    .data_in          (data_in),
    .full             (full),
    .wr_en            (wr_en),
    .wr_row           (wr_row),
    .page_hit         (page_hit),
    .table_scan_done  (table_scan_done)
  );

  column_fifo_bank #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) bank_i (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_row    (wr_row),
    .rd_en     (rd_en),
    .row_out   (row_out),
    .full      (full),
    .row_empty (row_empty)
  );

endmodule : page_scan_top

`default_nettype wire

// ==== logic/column_fifo_bank.sv ====
`default_nettype none
`timescale 1ns/10ps

module column_fifo_bank #(
  parameter int FIFO_DEPTH = 16                    // rows, power of two, 2 or more
) (
  input  logic           clk,
  input  logic           rst,                      // async, active low
  input  logic           wr_en,                    // push, writer checks full
  input  scan_pkg::row_t wr_row,
  input  logic           rd_en,                    // pop, ignored when empty
  output scan_pkg::row_t row_out,                  // head row, show-ahead
  output logic           full,
  output logic           row_empty
);

  import scan_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [PTR_W-1:0] wr_ptr;                        // next free slot
  logic [PTR_W-1:0] rd_ptr;                        // head slot
  logic [PTR_W:0]   occ;                           // rows held, 0..FIFO_DEPTH
  logic             pop;                           // qualified read

  //////////////////////////////////////////////////////////////////////
  // flags from occupancy before the edge
  //////////////////////////////////////////////////////////////////////

  assign full      = (occ == (PTR_W+1)'(FIFO_DEPTH));
  assign row_empty = (occ == '0);

  assign pop = rd_en && !row_empty;                // empty read dropped here

  //////////////////////////////////////////////////////////////////////
  // shared pointers
  //////////////////////////////////////////////////////////////////////

  // one pointer pair serves every column,
  // all columns move together
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      wr_ptr <= '0;
    else if (wr_en)
      wr_ptr <= wr_ptr + PTR_W'(1);                // wraps at FIFO_DEPTH
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      rd_ptr <= '0;
    else if (pop)
      rd_ptr <= rd_ptr + PTR_W'(1);
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      occ <= '0;
    else
    begin
      case ({wr_en, pop})
        2'b10:   occ <= occ + (PTR_W+1)'(1);       // push only
        2'b01:   occ <= occ - (PTR_W+1)'(1);       // pop only
        default: occ <= occ;                       // both or neither
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // column storage
  //////////////////////////////////////////////////////////////////////

  genvar c;
  generate
    for (c = 0; c < COL_COUNT; c++)
    begin : g_col
      logic [COL_W-1:0] mem [FIFO_DEPTH];          // one column's words

      always_ff @(posedge clk)
      begin
        if (wr_en)
          mem[wr_ptr] <= wr_row.col[c];            // visible next cycle
      end

      assign row_out.col[c] = mem[rd_ptr];         // async read of head
    end
  endgenerate

endmodule : column_fifo_bank

`default_nettype wire

// ==== logic/page_scan_fsm.sv ====
`default_nettype none
`timescale 1ns/10ps

module page_scan_fsm #(
  parameter int PAGE_BEATS = 128                     // beats per page, header included
) (
  input  logic                 clk,
  input  logic                 rst,                  // async, active low
  input  scan_pkg::page_addr_t target_page_addr,     // first page of the table
  input  logic [31:0]          record_num,           // rows wanted in total
  input  scan_pkg::page_addr_t read_page_addr,       // page being read now
  input  logic                 data_valid,           // one beat per high cycle
  input  scan_pkg::beat_u      data_in,
  input  logic                 full,                 // bank has no free row
  output logic                 wr_en,                // push wr_row this edge
  output scan_pkg::row_t       wr_row,
  output logic                 page_hit,             // inside a matched page
  output logic                 table_scan_done       // sticky until reset
);

  import scan_pkg::*;

  localparam int BCNT_W = $clog2(PAGE_BEATS + 1);  // holds 0..PAGE_BEATS

  scan_state_t       state;                        // current state
  scan_state_t       state_nxt;                    // next state
  logic [BCNT_W-1:0] beat_cnt;                     // beats of this page taken
  logic [31:0]       row_cnt;                      // rows written toward record_num
  page_addr_t        link_addr;                    // next_page of last header
  logic              link_vld;                     // link_addr holds a real header value
  logic              addr_match;                   // read address names our page
  logic              last_beat;                    // valid beat closes the page
  logic              last_row;                     // this write reaches record_num

  //////////////////////////////////////////////////////////////////////
  // match and beat decode
  //////////////////////////////////////////////////////////////////////

  // link only counts once a header was seen,
  // else page 0 would match out of reset
  assign addr_match = (read_page_addr == target_page_addr) ||
                      (link_vld && (read_page_addr == link_addr));

  assign last_beat = data_valid &&
                     (beat_cnt == BCNT_W'(PAGE_BEATS - 1));   // beat number PAGE_BEATS

  // no stall to the source, a beat seen while full is dropped
  assign wr_en = (state == load_rows) && data_valid && !full &&
                 (row_cnt < record_num);

  assign wr_row = data_in.row;                     // row view of the beat

  assign last_row = wr_en && ((row_cnt + 32'd1) == record_num);

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;                             // hold by default
    case (state)
      wait_page:
        if (addr_match)
          state_nxt = wait_header;                 // hit, header comes first
      wait_header:
        if (data_valid)
          state_nxt = load_rows;                   // header taken
      load_rows:
        if (last_beat)
          state_nxt = wait_page;                   // page end wins over done
        else if (last_row)
          state_nxt = skip_tail;
      skip_tail:
        if (last_beat)
          state_nxt = wait_page;
      default:
        state_nxt = wait_page;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      state    <= wait_page;
      page_hit <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      page_hit <= (state_nxt != wait_page);       // high from hit edge to page end
    end
  end

  // beat counter, header counts as beat 1
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      beat_cnt <= '0;
    else if (state_nxt == wait_page)
      beat_cnt <= '0;                              // idle or page just ended
    else if (data_valid && (state != wait_page))
      beat_cnt <= beat_cnt + BCNT_W'(1);
  end

  // row counter runs across pages until record_num
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      row_cnt <= '0;
    else if (last_row)
      row_cnt <= '0;                               // cleared when done is set
    else if (wr_en)
      row_cnt <= row_cnt + 32'd1;
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      table_scan_done <= 1'b0;
    else if (last_row)
      table_scan_done <= 1'b1;                     // never falls
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      link_vld <= 1'b0;
    else if ((state == wait_header) && data_valid)
      link_vld <= 1'b1;                            // first header seen
  end

  // link address, read through the header view
  always_ff @(posedge clk)
  begin
    if ((state == wait_header) && data_valid)
      link_addr <= data_in.hdr.next_page;
  end

endmodule : page_scan_fsm

`default_nettype wire

// ==== logic/scan_pkg.sv ====
`default_nettype none

package scan_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int COL_W     = 32;                   // one column word
  localparam int COL_COUNT = 8;                    // columns per table row
  localparam int BEAT_W    = COL_COUNT * COL_W;    // one data beat, 256 bits

  typedef logic [31:0] page_addr_t;                // page address on the read side

  //////////////////////////////////////////////////////////////////////
  // beat layouts
  //////////////////////////////////////////////////////////////////////

  // one table row, column 0 in the low word
  typedef struct packed {
    logic [COL_COUNT-1:0][COL_W-1:0] col;          // col[0] = bits 31:0
  } row_t;

  // first beat of every page
  typedef struct packed {
    logic [BEAT_W-COL_W-1:0] rsvd;                 // unused upper bits
    page_addr_t              next_page;            // link to the following page
  } header_t;

  // same 256-bit word, read as header or as row
  // depending on where it sits in the page
  typedef union packed {
    header_t hdr;                                  // beat 0 of a page
    row_t    row;                                  // beats 1 and up
  } beat_u;

  //////////////////////////////////////////////////////////////////////
  // scanner states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    wait_page   = 2'd0,                            // watch read_page_addr
    wait_header = 2'd1,                            // page hit, header next
    load_rows   = 2'd2,                            // rows go to the bank
    skip_tail   = 2'd3                             // record_num reached
  } scan_state_t;

endpackage : scan_pkg

`default_nettype wire
